/* spmm_settings.svh */
// Size and depth settings for the sparse-dense matrix multiplier
`ifndef SPMM_SETTINGS_SVH
`define SPMM_SETTINGS_SVH

// ========================================
// Data widths
// ========================================
`define SPMM_DATA_WIDTH 8
`define SPMM_NODE_WIDTH 8

// Sixteen products of 255 x 255 fit in 21 bits
`define SPMM_WH_WIDTH 21

// ========================================
// Matrix shape
// ========================================
// Columns of H, also the weight row count
`define SPMM_FEAT_IN 16
// Output features, one PE each
`define SPMM_FEAT_OUT 4

// ========================================
// Memory and buffer depths
// ========================================
`define SPMM_H_DEPTH 256
`define SPMM_NODE_DEPTH 64
`define SPMM_FIFO_DEPTH 8

`endif

/* spmm_pkg.sv */
// Shared vector types and the consumer state enum of the matrix multiplier
`include "spmm_settings.svh"

package spmm_pkg;

  // ========================================
  // Scalar fields
  // ========================================
  typedef logic [`SPMM_DATA_WIDTH-1:0] data_t;
  typedef logic [$clog2(`SPMM_FEAT_IN)-1:0] col_idx_t;
  // Row length runs 1 to FEAT_IN, so one extra bit
  typedef logic [$clog2(`SPMM_FEAT_IN):0] row_len_t;
  typedef logic [`SPMM_NODE_WIDTH-1:0] num_node_t;

  // ========================================
  // Addresses and counts
  // ========================================
  typedef logic [$clog2(`SPMM_H_DEPTH)-1:0] h_addr_t;
  // Also used as the Wh row address
  typedef logic [$clog2(`SPMM_NODE_DEPTH)-1:0] node_addr_t;
  typedef logic [$clog2(`SPMM_NODE_DEPTH):0] row_cnt_t;

  // ========================================
  // Result and weight vectors
  // ========================================
  typedef logic [`SPMM_WH_WIDTH-1:0] wh_data_t;
  // Feature 0 sits in the low bits
  typedef logic [`SPMM_FEAT_OUT*`SPMM_WH_WIDTH-1:0] wh_vec_t;
  typedef logic [`SPMM_FEAT_OUT*`SPMM_DATA_WIDTH-1:0] wgt_row_t;

  typedef enum logic {
    PE_IDLE,
    PE_RUN
  } pe_state_t;

endpackage

/* spmm_info_if.sv */
// Node-info channel between the row fetcher, the FIFO and the PE array
`timescale 1ns/1ps

interface spmm_info_if;

  // Write side, fetcher to FIFO
  logic                 wr_en;
  spmm_pkg::row_len_t   wr_row_len;
  spmm_pkg::num_node_t  wr_num_node;
  logic                 wr_src_flag;
  logic                 full;

  // Read side, FIFO head to PE array
  logic                 rd_en;
  spmm_pkg::row_len_t   rd_row_len;
  spmm_pkg::num_node_t  rd_num_node;
  logic                 rd_src_flag;
  logic                 empty;

  modport fetch (
    output wr_en,
    output wr_row_len,
    output wr_num_node,
    output wr_src_flag,
    input  full
  );

  modport fifo (
    input  wr_en,
    input  wr_row_len,
    input  wr_num_node,
    input  wr_src_flag,
    output full,
    input  rd_en,
    output rd_row_len,
    output rd_num_node,
    output rd_src_flag,
    output empty
  );

  // Show-ahead read, head word is valid while empty is low
  modport pe (
    output rd_en,
    input  rd_row_len,
    input  rd_num_node,
    input  rd_src_flag,
    input  empty
  );

endinterface

/* spmm_row_fetch.sv */
// Row fetcher that streams node-info words from memory into the node-info FIFO
`timescale 1ns/1ps

module spmm_row_fetch (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 start_i,
  input  spmm_pkg::row_cnt_t   num_rows_i,

  // Node-info memory, data one cycle after address
  output spmm_pkg::node_addr_t node_addr_o,
  input  spmm_pkg::row_len_t   node_row_len_i,
  input  spmm_pkg::num_node_t  node_num_node_i,
  input  logic                 node_src_flag_i,

  spmm_info_if.fetch           info
);

  spmm_pkg::row_cnt_t rows_q;
  spmm_pkg::row_cnt_t rd_cnt_q;
  logic               rd_pend_q;
  logic               rows_left;
  logic               rd_issue;

  // ========================================
  // Read pacing
  // ========================================
  assign rows_left = (rd_cnt_q != rows_q);

  // One read in flight, so the push lands before full is sampled again
  assign rd_issue = rows_left && !info.full && !rd_pend_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rows_q    <= '0;
      rd_cnt_q  <= '0;
      rd_pend_q <= 1'b0;
    end else if (start_i) begin
      rows_q    <= num_rows_i;
      rd_cnt_q  <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= rd_issue;
      if (rd_issue) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
      end
    end
  end

  // Read count doubles as the node-info address
  assign node_addr_o = spmm_pkg::node_addr_t'(rd_cnt_q);

  // ========================================
  // FIFO write side
  // ========================================
  // Returned word arrives the cycle after the read
  assign info.wr_en       = rd_pend_q;
  assign info.wr_row_len  = node_row_len_i;
  assign info.wr_num_node = node_num_node_i;
  assign info.wr_src_flag = node_src_flag_i;

  // Full comes from the FIFO, pacing here must keep pushes clear of it
  a_no_push_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    info.wr_en |-> !info.full
  );

endmodule

/* spmm_info_fifo.sv */
// Show-ahead FIFO holding node-info words between the fetcher and the PE array
`timescale 1ns/1ps
`include "spmm_settings.svh"

module spmm_info_fifo (
  input  logic      clk,
  input  logic      rst_n,

  spmm_info_if.fifo info
);

  localparam int DEPTH = `SPMM_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  spmm_pkg::row_len_t  row_len_mem  [DEPTH];
  spmm_pkg::num_node_t num_node_mem [DEPTH];
  logic                src_flag_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign push = info.wr_en;
  assign pop  = info.rd_en;

  // ========================================
  // Storage
  // ========================================
  always_ff @(posedge clk) begin
    if (push) begin
      row_len_mem[wr_ptr_q]  <= info.wr_row_len;
      num_node_mem[wr_ptr_q] <= info.wr_num_node;
      src_flag_mem[wr_ptr_q] <= info.wr_src_flag;
    end
  end

  // ========================================
  // Pointers and occupancy
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign info.full  = (count_q == CNT_W'(DEPTH));
  assign info.empty = (count_q == '0);

  // Head word shown ahead of the pop
  assign info.rd_row_len  = row_len_mem[rd_ptr_q];
  assign info.rd_num_node = num_node_mem[rd_ptr_q];
  assign info.rd_src_flag = src_flag_mem[rd_ptr_q];

  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> (!info.full || pop)
  );

  a_no_underflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> !info.empty
  );

endmodule

/* spmm_pe_array.sv */
// PE array that walks each sparse row, accumulates value x weight per feature, emits Wh words
`timescale 1ns/1ps
`include "spmm_settings.svh"

module spmm_pe_array (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 start_i,
  input  spmm_pkg::row_cnt_t   num_rows_i,

  spmm_info_if.pe              info,

  // Nonzero memory with data one cycle after address
  output spmm_pkg::h_addr_t    h_addr_o,
  input  spmm_pkg::col_idx_t   h_col_i,
  input  spmm_pkg::data_t      h_val_i,

  // Weight memory with one row word shared by all features
  output spmm_pkg::col_idx_t   wgt_addr_o,
  input  spmm_pkg::wgt_row_t   wgt_row_i,

  // Wh write port
  output logic                 wh_vld_o,
  output spmm_pkg::node_addr_t wh_addr_o,
  output spmm_pkg::wh_vec_t    wh_res_o,
  output spmm_pkg::num_node_t  wh_num_node_o,
  output logic                 wh_src_flag_o,

  output logic                 busy_o
);

  localparam int DW = `SPMM_DATA_WIDTH;
  localparam int WW = `SPMM_WH_WIDTH;
  localparam int NF = `SPMM_FEAT_OUT;

  spmm_pkg::pe_state_t  state_q;
  spmm_pkg::row_cnt_t   rows_q;
  spmm_pkg::row_cnt_t   done_cnt_q;
  spmm_pkg::row_len_t   nz_cnt_q;
  spmm_pkg::h_addr_t    h_addr_q;
  spmm_pkg::node_addr_t wh_addr_q;

  logic issue;
  logic first_nz;
  logic last_nz;

  // Stage 1 holds returning nonzero data
  logic                s1_vld_q;
  logic                s1_first_q;
  logic                s1_last_q;
  spmm_pkg::num_node_t s1_num_node_q;
  logic                s1_flag_q;

  // Stage 2 takes the weight row and does the MAC
  logic                s2_vld_q;
  logic                s2_first_q;
  logic                s2_last_q;
  spmm_pkg::data_t     s2_val_q;
  spmm_pkg::num_node_t s2_num_node_q;
  logic                s2_flag_q;

  // Stage 3 presents the sums
  logic                s3_vld_q;
  logic                s3_last_q;
  spmm_pkg::num_node_t s3_num_node_q;
  logic                s3_flag_q;

  // ========================================
  // Run control
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= spmm_pkg::PE_IDLE;
      rows_q     <= '0;
      done_cnt_q <= '0;
    end else begin
      case (state_q)
        spmm_pkg::PE_IDLE: begin
          if (start_i) begin
            state_q    <= spmm_pkg::PE_RUN;
            rows_q     <= num_rows_i;
            done_cnt_q <= '0;
          end
        end
        default: begin
          if (wh_vld_o) begin
            done_cnt_q <= done_cnt_q + 1'b1;
            // Busy drops the cycle after the last row is written
            if (done_cnt_q == rows_q - 1'b1) begin
              state_q <= spmm_pkg::PE_IDLE;
            end
          end
        end
      endcase
    end
  end

  assign busy_o = (state_q == spmm_pkg::PE_RUN);

  // ========================================
  // Nonzero issue
  // ========================================
  assign issue    = (state_q == spmm_pkg::PE_RUN) && !info.empty;
  assign first_nz = (nz_cnt_q == '0);
  assign last_nz  = (nz_cnt_q == info.rd_row_len - 1'b1);

  // Pop on the last nonzero so the next row follows back to back
  assign info.rd_en = issue && last_nz;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nz_cnt_q  <= '0;
      h_addr_q  <= '0;
      wh_addr_q <= '0;
    end else if (start_i) begin
      nz_cnt_q  <= '0;
      h_addr_q  <= '0;
      wh_addr_q <= '0;
    end else begin
      if (issue) begin
        nz_cnt_q <= last_nz ? '0 : nz_cnt_q + 1'b1;
        h_addr_q <= h_addr_q + 1'b1;
      end
      if (wh_vld_o) begin
        wh_addr_q <= wh_addr_q + 1'b1;
      end
    end
  end

  assign h_addr_o   = h_addr_q;
  assign wgt_addr_o = s1_vld_q ? h_col_i : '0;

  // ========================================
  // Pipeline
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q <= 1'b0;
      s2_vld_q <= 1'b0;
      s3_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= issue;
      s2_vld_q <= s1_vld_q;
      s3_vld_q <= s2_vld_q;
    end
  end

  // Row tags ride along with each nonzero
  always_ff @(posedge clk) begin
    s1_first_q    <= first_nz;
    s1_last_q     <= last_nz;
    s1_num_node_q <= info.rd_num_node;
    s1_flag_q     <= info.rd_src_flag;
    s2_first_q    <= s1_first_q;
    s2_last_q     <= s1_last_q;
    s2_val_q      <= h_val_i;
    s2_num_node_q <= s1_num_node_q;
    s2_flag_q     <= s1_flag_q;
    s3_last_q     <= s2_last_q;
    s3_num_node_q <= s2_num_node_q;
    s3_flag_q     <= s2_flag_q;
  end

  // ========================================
  // Per-feature MAC
  // ========================================
  for (genvar f = 0; f < NF; f++) begin : g_pe
    spmm_pkg::data_t  wgt;
    logic [2*DW-1:0]  prod;
    spmm_pkg::wh_data_t acc_q;

    assign wgt  = wgt_row_i[f*DW +: DW];
    assign prod = s2_val_q * wgt;

    // First nonzero of a row restarts the sum
    always_ff @(posedge clk) begin
      if (s2_vld_q) begin
        acc_q <= (s2_first_q ? '0 : acc_q) + spmm_pkg::wh_data_t'(prod);
      end
    end

    assign wh_res_o[f*WW +: WW] = acc_q;
  end

  assign wh_vld_o      = s3_vld_q && s3_last_q;
  assign wh_addr_o     = wh_addr_q;
  assign wh_num_node_o = s3_num_node_q;
  assign wh_src_flag_o = s3_flag_q;

  // Every row holds at least one nonzero
  a_row_len_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n)
    info.rd_en |-> (info.rd_row_len != '0)
  );

endmodule

/* spmm_top.sv */
// Top level of the sparse-dense multiplier, wiring fetcher, FIFO and PE array to memory ports
`timescale 1ns/1ps

module spmm_top (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 start_i,
  input  spmm_pkg::row_cnt_t   num_rows_i,
  output logic                 busy_o,

  // Node-info memory
  output spmm_pkg::node_addr_t node_addr_o,
  input  spmm_pkg::row_len_t   node_row_len_i,
  input  spmm_pkg::num_node_t  node_num_node_i,
  input  logic                 node_src_flag_i,

  // Nonzero memory
  output spmm_pkg::h_addr_t    h_addr_o,
  input  spmm_pkg::col_idx_t   h_col_i,
  input  spmm_pkg::data_t      h_val_i,

  // Weight memory
  output spmm_pkg::col_idx_t   wgt_addr_o,
  input  spmm_pkg::wgt_row_t   wgt_row_i,

  // Wh write port
  output logic                 wh_vld_o,
  output spmm_pkg::node_addr_t wh_addr_o,
  output spmm_pkg::wh_vec_t    wh_res_o,
  output spmm_pkg::num_node_t  wh_num_node_o,
  output logic                 wh_src_flag_o
);

  spmm_info_if info_if ();

  spmm_row_fetch u_row_fetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .num_rows_i      (num_rows_i),
    .node_addr_o     (node_addr_o),
    .node_row_len_i  (node_row_len_i),
    .node_num_node_i (node_num_node_i),
    .node_src_flag_i (node_src_flag_i),
    .info            (info_if.fetch)
  );

  spmm_info_fifo u_info_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .info  (info_if.fifo)
  );

  spmm_pe_array u_pe_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .num_rows_i    (num_rows_i),
    .info          (info_if.pe),
    .h_addr_o      (h_addr_o),
    .h_col_i       (h_col_i),
    .h_val_i       (h_val_i),
    .wgt_addr_o    (wgt_addr_o),
    .wgt_row_i     (wgt_row_i),
    .wh_vld_o      (wh_vld_o),
    .wh_addr_o     (wh_addr_o),
    .wh_res_o      (wh_res_o),
    .wh_num_node_o (wh_num_node_o),
    .wh_src_flag_o (wh_src_flag_o),
    .busy_o        (busy_o)
  );

endmodule

/* tb_spmm_top.sv */
// Table-driven testbench for the sparse-dense multiplier with memory models and a reference model
`timescale 1ns/1ps
`include "spmm_settings.svh"

module tb_spmm_top;

  localparam int NUM_TESTS = 5;
  localparam int DW = `SPMM_DATA_WIDTH;
  localparam int WW = `SPMM_WH_WIDTH;
  localparam int NF = `SPMM_FEAT_OUT;
  localparam int NI = `SPMM_FEAT_IN;
  localparam int HD = `SPMM_H_DEPTH;
  localparam int ND = `SPMM_NODE_DEPTH;

  // ========================================
  // DUT signals
  // ========================================
  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  logic                 start_i = 1'b0;
  spmm_pkg::row_cnt_t   num_rows_i = '0;
  logic                 busy_o;
  spmm_pkg::node_addr_t node_addr_o;
  spmm_pkg::row_len_t   node_row_len_i = '0;
  spmm_pkg::num_node_t  node_num_node_i = '0;
  logic                 node_src_flag_i = 1'b0;
  spmm_pkg::h_addr_t    h_addr_o;
  spmm_pkg::col_idx_t   h_col_i = '0;
  spmm_pkg::data_t      h_val_i = '0;
  spmm_pkg::col_idx_t   wgt_addr_o;
  spmm_pkg::wgt_row_t   wgt_row_i = '0;
  logic                 wh_vld_o;
  spmm_pkg::node_addr_t wh_addr_o;
  spmm_pkg::wh_vec_t    wh_res_o;
  spmm_pkg::num_node_t  wh_num_node_o;
  logic                 wh_src_flag_o;

  // ========================================
  // Test table
  // ========================================
  // Mask bits are forced to one in every value and weight
  string           tbl_name [NUM_TESTS] = '{"single_nz", "random_rows", "fifo_fill",
                                            "max_values", "restart"};
  int              tbl_rows [NUM_TESTS] = '{1, 12, 40, 4, 6};
  int              tbl_min  [NUM_TESTS] = '{1, 1, 6, 16, 1};
  int              tbl_max  [NUM_TESTS] = '{1, 16, 6, 16, 8};
  spmm_pkg::data_t tbl_mask [NUM_TESTS] = '{8'h00, 8'h00, 8'h00, 8'hff, 8'h00};

  // Memory models and reference results
  spmm_pkg::row_len_t   node_len_mem  [ND];
  spmm_pkg::num_node_t  node_num_mem  [ND];
  logic                 node_flag_mem [ND];
  spmm_pkg::col_idx_t   h_col_mem     [HD];
  spmm_pkg::data_t      h_val_mem     [HD];
  spmm_pkg::wgt_row_t   wgt_mem       [NI];
  spmm_pkg::wh_vec_t    exp_wh        [ND];
  spmm_pkg::num_node_t  exp_num       [ND];
  logic                 exp_flag      [ND];

  // Addresses sampled mid-cycle
  spmm_pkg::node_addr_t node_addr_s = '0;
  spmm_pkg::h_addr_t    h_addr_s = '0;
  spmm_pkg::col_idx_t   wgt_addr_s = '0;

  spmm_pkg::wh_vec_t    got_wh   [$];
  spmm_pkg::node_addr_t got_addr [$];
  spmm_pkg::num_node_t  got_num  [$];
  logic                 got_flag [$];

  logic [31:0] lfsr_q = 32'hba9f_957a;
  int          err_cnt = 0;
  int          fail_tests = 0;

  spmm_top dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .num_rows_i      (num_rows_i),
    .busy_o          (busy_o),
    .node_addr_o     (node_addr_o),
    .node_row_len_i  (node_row_len_i),
    .node_num_node_i (node_num_node_i),
    .node_src_flag_i (node_src_flag_i),
    .h_addr_o        (h_addr_o),
    .h_col_i         (h_col_i),
    .h_val_i         (h_val_i),
    .wgt_addr_o      (wgt_addr_o),
    .wgt_row_i       (wgt_row_i),
    .wh_vld_o        (wh_vld_o),
    .wh_addr_o       (wh_addr_o),
    .wh_res_o        (wh_res_o),
    .wh_num_node_o   (wh_num_node_o),
    .wh_src_flag_o   (wh_src_flag_o)
  );

  always #10 clk = ~clk;

  // ========================================
  // One-cycle read memories
  // ========================================
  always @(negedge clk) begin
    node_addr_s = node_addr_o;
    h_addr_s    = h_addr_o;
    wgt_addr_s  = wgt_addr_o;
  end

  always @(posedge clk) begin
    #2;
    node_row_len_i  = node_len_mem[node_addr_s];
    node_num_node_i = node_num_mem[node_addr_s];
    node_src_flag_i = node_flag_mem[node_addr_s];
    h_col_i         = h_col_mem[h_addr_s];
    h_val_i         = h_val_mem[h_addr_s];
    wgt_row_i       = wgt_mem[wgt_addr_s];
  end

  // Wh writes collected where outputs are stable
  always @(negedge clk) begin
    if (rst_n && wh_vld_o) begin
      got_wh.push_back(wh_res_o);
      got_addr.push_back(wh_addr_o);
      got_num.push_back(wh_num_node_o);
      got_flag.push_back(wh_src_flag_o);
    end
  end

  // ========================================
  // Random numbers and reference model
  // ========================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic fill_memories(input int t);
    int span;
    span = tbl_max[t] - tbl_min[t] + 1;
    for (int a = 0; a < HD; a++) begin
      h_col_mem[a] = spmm_pkg::col_idx_t'(rand_bits(4));
      h_val_mem[a] = spmm_pkg::data_t'(rand_bits(DW)) | tbl_mask[t];
    end
    for (int c = 0; c < NI; c++) begin
      wgt_mem[c] = spmm_pkg::wgt_row_t'(rand_bits(NF * DW)) | {NF{tbl_mask[t]}};
    end
    for (int r = 0; r < ND; r++) begin
      node_len_mem[r]  = spmm_pkg::row_len_t'(tbl_min[t] + int'(rand_bits(4)) % span);
      node_num_mem[r]  = spmm_pkg::num_node_t'(rand_bits(8));
      node_flag_mem[r] = rand_bits(1) != 0;
    end
  endtask

  // Nonzeros sit back to back from address 0
  task automatic build_expected(input int t);
    int base;
    int sum [NF];
    int a;
    spmm_pkg::wgt_row_t w;
    base = 0;
    for (int r = 0; r < tbl_rows[t]; r++) begin
      for (int f = 0; f < NF; f++) sum[f] = 0;
      for (int k = 0; k < int'(node_len_mem[r]); k++) begin
        a = (base + k) % HD;
        w = wgt_mem[h_col_mem[a]];
        for (int f = 0; f < NF; f++) begin
          sum[f] += int'(h_val_mem[a]) * int'(w[f*DW +: DW]);
        end
      end
      for (int f = 0; f < NF; f++) begin
        exp_wh[r][f*WW +: WW] = spmm_pkg::wh_data_t'(sum[f]);
      end
      exp_num[r]  = node_num_mem[r];
      exp_flag[r] = node_flag_mem[r];
      base += int'(node_len_mem[r]);
    end
  endtask

  // ========================================
  // Checks
  // ========================================
  task automatic report_failure(input string msg);
    $display("Error: %s", msg);
    err_cnt++;
  endtask

  task automatic check_wh(input int row, input spmm_pkg::wh_vec_t got,
                          input spmm_pkg::wh_vec_t exp);
    if (got !== exp) begin
      $display("Mismatch wh_res_o row %0d: got 0x%h, expected 0x%h", row, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_num_node(input int row, input spmm_pkg::num_node_t got,
                                input spmm_pkg::num_node_t exp);
    if (got !== exp) begin
      $display("Mismatch wh_num_node_o row %0d: got 0x%h, expected 0x%h", row, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input int row, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch wh_src_flag_o row %0d: got 0x%h, expected 0x%h", row, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input int row, input spmm_pkg::node_addr_t got,
                            input spmm_pkg::node_addr_t exp);
    if (got !== exp) begin
      $display("Mismatch wh_addr_o row %0d: got 0x%h, expected 0x%h", row, got, exp);
      err_cnt++;
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  task automatic run_test(input int t);
    int errs_at_start;
    int rows;
    int n;
    errs_at_start = err_cnt;
    rows = tbl_rows[t];
    fill_memories(t);
    build_expected(t);
    got_wh.delete();
    got_addr.delete();
    got_num.delete();
    got_flag.delete();

    @(posedge clk);
    #2;
    start_i    = 1'b1;
    num_rows_i = spmm_pkg::row_cnt_t'(rows);
    @(posedge clk);
    #2;
    start_i = 1'b0;
    if (busy_o !== 1'b1) report_failure($sformatf("%s: busy_o did not rise", tbl_name[t]));

    while (busy_o === 1'b1) begin
      @(posedge clk);
      #2;
    end
    repeat (4) @(posedge clk);
    #2;
    if (busy_o !== 1'b0) report_failure($sformatf("%s: busy_o high after run", tbl_name[t]));

    n = got_wh.size();
    if (n != rows) begin
      report_failure($sformatf("%s: expected %0d Wh writes, saw %0d", tbl_name[t], rows, n));
    end
    for (int i = 0; i < n && i < rows; i++) begin
      check_addr(i, got_addr[i], spmm_pkg::node_addr_t'(i));
      check_wh(i, got_wh[i], exp_wh[i]);
      check_num_node(i, got_num[i], exp_num[i]);
      check_flag(i, got_flag[i], exp_flag[i]);
    end

    // Full-scale rows must reach 16 x 255 x 255 in every feature
    if (tbl_mask[t] == 8'hff) begin
      for (int i = 0; i < n && i < rows; i++) begin
        check_wh(i, got_wh[i], {NF{spmm_pkg::wh_data_t'(1040400)}});
      end
    end

    if (err_cnt == errs_at_start) begin
      $display("%-12s rows=%0d writes=%0d ok", tbl_name[t], rows, n);
    end else begin
      fail_tests++;
      $display("%-12s rows=%0d writes=%0d FAIL, %0d errors", tbl_name[t], rows, n,
               err_cnt - errs_at_start);
    end
  endtask

  initial begin : watchdog
    int limit;
    limit = 16 + 50 * NUM_TESTS;
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit += tbl_rows[t] * (20 + 4 * tbl_max[t]);
    end
    repeat (limit) @(posedge clk);
    $display("Error: watchdog expired after %0d cycles, run did not finish", limit);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    repeat (16) @(posedge clk);
    #2;
    if (busy_o !== 1'b0 || wh_vld_o !== 1'b0) report_failure("busy or Wh strobe high in reset");
    if (node_addr_o !== '0 || h_addr_o !== '0 || wh_addr_o !== '0) begin
      report_failure("address outputs not zero in reset");
    end
    rst_n = 1'b1;

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end

    $display("Summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* spmm_top.f */
+incdir+.
spmm_pkg.sv
spmm_info_if.sv
spmm_row_fetch.sv
spmm_info_fifo.sv
spmm_pe_array.sv
spmm_top.sv
tb_spmm_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, result decided from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_spmm_top \
  -f spmm_top.f -o sim_spmm \
  && ./obj_dir/sim_spmm > sim.log 2>&1
cat sim.log 2> /dev/null
grep -qx "Test passed" sim.log && echo "Simulation run OK" \
  || { echo "Simulation run FAILED"; exit 1; }
